// ==== rvv_decode_top.f ====
source/rvv_decode_pkg.sv
source/decode_uop_if.sv
source/rvv_cmd_queue.sv
source/rvv_decode_unit.sv
source/rvv_decode_ctrl.sv
source/rvv_uop_queue.sv
source/rvv_decode_top.sv
sim/tb_rvv_decode_top.sv

// ==== sim/tb_rvv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_decode_top;
  import rvv_decode_pkg::*;

  logic        clk;
  logic        reset;
  logic        cmd_valid;
  logic [31:0] cmd_word;
  logic        cmd_ready;
  logic        uop_ready;
  logic        uop_valid;
  logic        uop_is_scalar;
  logic [5:0]  uop_funct;
  logic [4:0]  uop_vd;
  logic [4:0]  uop_vs2;
  logic [4:0]  uop_vs1;
  logic [12:0] uop_imm;
  logic [2:0]  uop_index;
  logic        uop_last;

  // stimulus table, one row per instruction
  logic [31:0] tbl_word [$];
  int          tbl_gap [$];
  bit          tbl_stall [$];

  uop_t        exp_q [$];
  uop_t        exp_uop;
  logic [31:0] rng_state;
  logic        next_ready;
  bit          stall_mode;
  bit          full_seen;
  bit          accepted;
  int          cycle_count;
  int          cycle_limit;

  rvv_decode_top u_rvv_decode_top (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_word      (cmd_word),
    .cmd_ready     (cmd_ready),
    .uop_ready     (uop_ready),
    .uop_valid     (uop_valid),
    .uop_is_scalar (uop_is_scalar),
    .uop_funct     (uop_funct),
    .uop_vd        (uop_vd),
    .uop_vs2       (uop_vs2),
    .uop_vs1       (uop_vs1),
    .uop_imm       (uop_imm),
    .uop_index     (uop_index),
    .uop_last      (uop_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] vv_word(input logic [5:0] funct, input logic [1:0] lmul,
                                          input logic [4:0] vd, input logic [4:0] vs2,
                                          input logic [4:0] vs1);
    return {1'b0, funct, lmul, vd, vs2, vs1, 8'h00};
  endfunction

  function automatic logic [31:0] vx_word(input logic [5:0] funct, input logic [1:0] lmul,
                                          input logic [4:0] vd, input logic [4:0] vs2,
                                          input logic [12:0] imm);
    return {1'b1, funct, lmul, vd, vs2, imm};
  endfunction

  task automatic add_entry(input logic [31:0] word, input int gap, input bit stall);
    tbl_word.push_back(word);
    tbl_gap.push_back(gap);
    tbl_stall.push_back(stall);
  endtask

  task automatic load_table();
    // two single-uop instructions back to back
    add_entry(vv_word(6'h01, 2'd0, 5'd2, 5'd8, 5'd16), 0, 1'b0);
    add_entry(vv_word(6'h02, 2'd0, 5'd3, 5'd9, 5'd17), 0, 1'b0);
    // 2 uops then 4 uops
    add_entry(vx_word(6'h03, 2'd1, 5'd4, 5'd10, 13'h1abc), 2, 1'b0);
    add_entry(vv_word(6'h04, 2'd2, 5'd8, 5'd12, 5'd20), 0, 1'b0);
    // long group holds unit 0 so the next ones queue up behind it
    add_entry(vv_word(6'h05, 2'd3, 5'd0, 5'd8, 5'd16), 5, 1'b0);
    // 8 uops right behind 2 uops
    add_entry(vv_word(6'h06, 2'd1, 5'd6, 5'd14, 5'd22), 0, 1'b0);
    add_entry(vx_word(6'h07, 2'd3, 5'd16, 5'd8, 13'h0f0f), 0, 1'b0);
    add_entry(vx_word(6'h08, 2'd0, 5'd1, 5'd5, 13'h1fff), 1, 1'b0);
    add_entry(vv_word(6'h09, 2'd2, 5'd12, 5'd4, 5'd24), 0, 1'b0);
    // random output stalls from here on
    add_entry(vx_word(6'h0a, 2'd2, 5'd20, 5'd0, 13'h0123), 4, 1'b1);
    add_entry(vv_word(6'h0b, 2'd3, 5'd8, 5'd16, 5'd0), 0, 1'b1);
    add_entry(vx_word(6'h0c, 2'd3, 5'd0, 5'd24, 13'h0a5a), 0, 1'b1);
    add_entry(vv_word(6'h0d, 2'd3, 5'd16, 5'd0, 5'd8), 0, 1'b1);
    add_entry(vv_word(6'h0e, 2'd0, 5'd31, 5'd30, 5'd29), 0, 1'b1);
    add_entry(vx_word(6'h0f, 2'd3, 5'd8, 5'd8, 13'h1001), 0, 1'b1);
    add_entry(vv_word(6'h10, 2'd2, 5'd4, 5'd12, 5'd20), 0, 1'b1);
  endtask

  // uop list from group size and the register offset rule
  task automatic build_expected();
    logic [31:0] w;
    logic [3:0]  n;
    uop_t        e;
    for (int i = 0; i < tbl_word.size(); i++) begin
      w = tbl_word[i];
      n = uop_count(w[24:23]);
      for (int idx = 0; idx < n; idx++) begin
        e.is_scalar = w[31];
        e.funct     = w[30:25];
        e.vd        = w[22:18] + 5'(idx);
        e.vs2       = w[17:13] + 5'(idx);
        e.vs1       = w[31] ? 5'd0 : w[12:8] + 5'(idx);
        e.imm       = w[31] ? w[12:0] : 13'd0;
        e.uop_index = 3'(idx);
        e.last_uop  = (idx == n - 1);
        exp_q.push_back(e);
      end
    end
  endtask

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ready decided from state at the edge, driven just after it
  always @(posedge clk) begin
    rng_state  = xorshift32(rng_state);
    next_ready = stall_mode ? rng_state[7] : 1'b1;
    #1;
    uop_ready = next_ready;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: uop stream not complete after %0d cycles", cycle_count);
      abort_run();
    end
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!reset && uop_valid && uop_ready) begin
      if (exp_q.size() == 0) begin
        $display("a uop came out with no instruction left to produce it");
        abort_run();
      end else begin
        exp_uop = exp_q.pop_front();
        compare_value("uop_is_scalar", 32'(uop_is_scalar), 32'(exp_uop.is_scalar));
        compare_value("uop_funct", 32'(uop_funct), 32'(exp_uop.funct));
        compare_value("uop_vd", 32'(uop_vd), 32'(exp_uop.vd));
        compare_value("uop_vs2", 32'(uop_vs2), 32'(exp_uop.vs2));
        compare_value("uop_vs1", 32'(uop_vs1), 32'(exp_uop.vs1));
        compare_value("uop_imm", 32'(uop_imm), 32'(exp_uop.imm));
        compare_value("uop_index", 32'(uop_index), 32'(exp_uop.uop_index));
        compare_value("uop_last", 32'(uop_last), 32'(exp_uop.last_uop));
      end
    end
  end

  initial begin
    reset       = 1'b1;
    cmd_valid   = 1'b0;
    cmd_word    = '0;
    uop_ready   = 1'b0;
    stall_mode  = 1'b0;
    full_seen   = 1'b0;
    rng_state   = 32'd99587;
    cycle_count = 0;
    load_table();
    build_expected();
    cycle_limit = 20 * exp_q.size() + 200;

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    @(negedge clk);
    compare_value("uop_valid", 32'(uop_valid), 32'd0);
    compare_value("cmd_ready", 32'(cmd_ready), 32'd1);
    @(posedge clk);
    #1;

    for (int i = 0; i < tbl_word.size(); i++) begin
      repeat (tbl_gap[i]) begin
        @(posedge clk);
        #1;
      end
      stall_mode = tbl_stall[i];
      cmd_word   = tbl_word[i];
      cmd_valid  = 1'b1;
      accepted   = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        if (!cmd_ready && stall_mode) begin
          full_seen = 1'b1;
        end
        accepted = cmd_ready;
        @(posedge clk);
        #1;
      end
      cmd_valid = 1'b0;
    end

    // drain, then watch for stray uops
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    if (!full_seen) begin
      $display("cmd_ready never dropped while the output was stalled");
      abort_run();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== source/decode_uop_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_uop_if;
  import rvv_decode_pkg::*;

  // unit holds an instruction
  logic                  pkg_valid;
  // contiguous from bit 0
  logic [NUM_DE_UOP-1:0] uop_valid;
  uop_t [NUM_DE_UOP-1:0] uop;

  modport unit (
    output pkg_valid,
    output uop_valid,
    output uop
  );

  modport ctrl (
    input pkg_valid,
    input uop_valid,
    input uop
  );

endinterface

`default_nettype wire

// ==== source/rvv_cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_cmd_queue #(
  parameter int CQ_DEPTH = 4
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       cmd_valid,
  input  rvv_decode_pkg::inst_word_u      cmd_word,
  output logic                            cmd_ready,
  input  wire logic                       pop0,
  input  wire logic                       pop1,
  output logic                            inst0_valid,
  output rvv_decode_pkg::inst_word_u      inst0,
  output logic                            inst1_valid,
  output rvv_decode_pkg::inst_word_u      inst1
);
  import rvv_decode_pkg::*;

  localparam int PTR_W = (CQ_DEPTH > 1) ? $clog2(CQ_DEPTH) : 1;
  localparam int SUM_W = PTR_W + 1;
  localparam int CNT_W = $clog2(CQ_DEPTH + 1);

  inst_word_u       mem [CQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             accept;
  logic [1:0]       pop_num;

  // pointer step with wrap at the buffer depth
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                input logic [1:0]       n);
    logic [SUM_W-1:0] sum;
    sum = {1'b0, ptr} + SUM_W'(n);
    if (sum >= SUM_W'(CQ_DEPTH)) begin
      sum = sum - SUM_W'(CQ_DEPTH);
    end
    return sum[PTR_W-1:0];
  endfunction

  assign cmd_ready = (count < CNT_W'(CQ_DEPTH));
  assign accept    = cmd_valid & cmd_ready;
  // pop1 never comes without pop0
  assign pop_num   = 2'(pop0) + 2'(pop1);

  // two oldest entries go straight to the decode units
  assign inst0_valid = (count >= CNT_W'(1));
  assign inst1_valid = (count >= CNT_W'(2));
  assign inst0       = mem[rd_ptr];
  assign inst1       = mem[ptr_add(rd_ptr, 2'd1)];

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[wr_ptr] <= cmd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= ptr_add(wr_ptr, 2'd1);
      end
      rd_ptr <= ptr_add(rd_ptr, pop_num);
      count  <= count + CNT_W'(accept) - CNT_W'(pop_num);
    end
  end

endmodule

`default_nettype wire

// ==== source/rvv_decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_ctrl (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  decode_uop_if.ctrl                                 de0,
  decode_uop_if.ctrl                                 de1,
  output logic [rvv_decode_pkg::UOP_INDEX_WIDTH-1:0] uop_index_remain,
  output logic                                       pop0,
  output logic                                       pop1,
  output logic                                       push0,
  output rvv_decode_pkg::uop_t                       data0,
  output logic                                       push1,
  output rvv_decode_pkg::uop_t                       data1,
  output logic                                       push2,
  output rvv_decode_pkg::uop_t                       data2,
  output logic                                       push3,
  output rvv_decode_pkg::uop_t                       data3,
  input  wire logic                                  fifo_full,
  input  wire logic                                  fifo_1left_to_full,
  input  wire logic                                  fifo_2left_to_full,
  input  wire logic                                  fifo_3left_to_full
);
  import rvv_decode_pkg::*;

  localparam int QTY_W = $clog2(NUM_DE_UOP + 1);

  logic [QTY_W-1:0]      quantity;
  logic [QTY_W-1:0]      free_slots;
  logic                  unit0_last;
  logic                  unit1_last;
  logic                  fifo_ready;
  logic [NUM_DE_UOP-1:0] push_vec;
  uop_t [NUM_DE_UOP-1:0] data_vec;

  // uop queue needs four free entries before anything moves
  assign fifo_ready = !(fifo_full | fifo_1left_to_full |
                        fifo_2left_to_full | fifo_3left_to_full);

  // unit 0 uops this cycle, and where its last uop sits
  always_comb begin
    quantity   = '0;
    unit0_last = 1'b0;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      quantity   = quantity + QTY_W'(de0.uop_valid[k]);
      unit0_last = unit0_last | (de0.uop_valid[k] & de0.uop[k].last_uop);
    end
  end

  assign free_slots = QTY_W'(NUM_DE_UOP) - quantity;

  // unit 1 finishes only if its last uop fits in the leftover slots
  always_comb begin
    unit1_last = 1'b0;
    for (int j = 0; j < NUM_DE_UOP; j++) begin
      if (QTY_W'(j) < free_slots) begin
        unit1_last = unit1_last | (de1.uop_valid[j] & de1.uop[j].last_uop);
      end
    end
  end

  assign pop0 = de0.pkg_valid & unit0_last & fifo_ready;
  assign pop1 = de1.pkg_valid & unit1_last & pop0;

  // slot k: unit 0 first, then unit 1 shifted down by quantity
  always_comb begin
    logic [QTY_W-1:0] sel;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      sel = QTY_W'(k) - quantity;
      if (QTY_W'(k) < quantity) begin
        push_vec[k] = fifo_ready & de0.uop_valid[k];
        data_vec[k] = de0.uop[k];
      end else if (pop0 && de1.uop_valid[sel[1:0]]) begin
        push_vec[k] = 1'b1;
        data_vec[k] = de1.uop[sel[1:0]];
      end else begin
        push_vec[k] = 1'b0;
        data_vec[k] = '0;
      end
    end
  end

  assign push0 = push_vec[0];
  assign push1 = push_vec[1];
  assign push2 = push_vec[2];
  assign push3 = push_vec[3];
  assign data0 = data_vec[0];
  assign data1 = data_vec[1];
  assign data2 = data_vec[2];
  assign data3 = data_vec[3];

  // start index of whatever instruction sits in unit 0 next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      uop_index_remain <= '0;
    end else if (de0.pkg_valid && fifo_ready) begin
      if (!unit0_last) begin
        uop_index_remain <= uop_index_remain + UOP_INDEX_WIDTH'(NUM_DE_UOP);
      end else if (de1.pkg_valid && !unit1_last) begin
        // unit 1 moves up and resumes after the uops taken here
        uop_index_remain <= UOP_INDEX_WIDTH'(free_slots);
      end else begin
        uop_index_remain <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rvv_decode_pkg.sv ====
`default_nettype none

package rvv_decode_pkg;

  // uops offered by one decode unit per cycle
  localparam int unsigned NUM_DE_UOP      = 32'd4;
  // largest register group is 8 uops
  localparam int unsigned UOP_INDEX_WIDTH = 32'd3;

  // vector-vector view of the instruction word
  typedef struct packed {
    logic       is_scalar;
    logic [5:0] funct;
    logic [1:0] lmul;
    logic [4:0] vd;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [7:0] spare;
  } inst_vv_t;

  // vector-scalar view, immediate sits where vs1 and spare were
  typedef struct packed {
    logic        is_scalar;
    logic [5:0]  funct;
    logic [1:0]  lmul;
    logic [4:0]  vd;
    logic [4:0]  vs2;
    logic [12:0] imm;
  } inst_vx_t;

  typedef union packed {
    inst_vv_t vv;
    inst_vx_t vx;
  } inst_word_u;

  // one micro-op as stored in the uop queue
  typedef struct packed {
    logic                       is_scalar;
    logic [5:0]                 funct;
    logic [4:0]                 vd;
    logic [4:0]                 vs2;
    logic [4:0]                 vs1;
    logic [12:0]                imm;
    logic [UOP_INDEX_WIDTH-1:0] uop_index;
    logic                       last_uop;
  } uop_t;

  // lmul 0..3 gives 1, 2, 4 or 8 uops
  function automatic logic [3:0] uop_count(input logic [1:0] lmul);
    return 4'd1 << lmul;
  endfunction

endpackage

`default_nettype wire

// ==== source/rvv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_top #(
  parameter int CQ_DEPTH = 4,
  parameter int UQ_DEPTH = 16
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        cmd_valid,
  input  wire logic [31:0] cmd_word,
  output logic             cmd_ready,
  input  wire logic        uop_ready,
  output logic             uop_valid,
  output logic             uop_is_scalar,
  output logic [5:0]       uop_funct,
  output logic [4:0]       uop_vd,
  output logic [4:0]       uop_vs2,
  output logic [4:0]       uop_vs1,
  output logic [12:0]      uop_imm,
  output logic [2:0]       uop_index,
  output logic             uop_last
);
  import rvv_decode_pkg::*;

  inst_word_u                 cmd_inst;
  inst_word_u                 unit_inst [2];
  logic                       unit_inst_valid [2];
  logic [UOP_INDEX_WIDTH-1:0] unit_start [2];
  logic [UOP_INDEX_WIDTH-1:0] uop_index_remain;
  logic                       pop0;
  logic                       pop1;
  logic                       push0;
  logic                       push1;
  logic                       push2;
  logic                       push3;
  uop_t                       data0;
  uop_t                       data1;
  uop_t                       data2;
  uop_t                       data3;
  logic                       fifo_full;
  logic                       fifo_1left_to_full;
  logic                       fifo_2left_to_full;
  logic                       fifo_3left_to_full;
  uop_t                       uq_uop;

  assign cmd_inst = cmd_word;

  rvv_cmd_queue #(
    .CQ_DEPTH (CQ_DEPTH)
  ) u_cmd_queue (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_word    (cmd_inst),
    .cmd_ready   (cmd_ready),
    .pop0        (pop0),
    .pop1        (pop1),
    .inst0_valid (unit_inst_valid[0]),
    .inst0       (unit_inst[0]),
    .inst1_valid (unit_inst_valid[1]),
    .inst1       (unit_inst[1])
  );

  // unit 1 always decodes from the first uop
  assign unit_start[0] = uop_index_remain;
  assign unit_start[1] = '0;

  decode_uop_if de_if [2] ();

  for (genvar g = 0; g < 2; g++) begin : g_unit
    rvv_decode_unit u_decode_unit (
      .inst_valid  (unit_inst_valid[g]),
      .inst        (unit_inst[g]),
      .start_index (unit_start[g]),
      .de          (de_if[g])
    );
  end

  rvv_decode_ctrl u_decode_ctrl (
    .clk                (clk),
    .reset              (reset),
    .de0                (de_if[0]),
    .de1                (de_if[1]),
    .uop_index_remain   (uop_index_remain),
    .pop0               (pop0),
    .pop1               (pop1),
    .push0              (push0),
    .data0              (data0),
    .push1              (push1),
    .data1              (data1),
    .push2              (push2),
    .data2              (data2),
    .push3              (push3),
    .data3              (data3),
    .fifo_full          (fifo_full),
    .fifo_1left_to_full (fifo_1left_to_full),
    .fifo_2left_to_full (fifo_2left_to_full),
    .fifo_3left_to_full (fifo_3left_to_full)
  );

  rvv_uop_queue #(
    .UQ_DEPTH (UQ_DEPTH)
  ) u_uop_queue (
    .clk                (clk),
    .reset              (reset),
    .push0              (push0),
    .data0              (data0),
    .push1              (push1),
    .data1              (data1),
    .push2              (push2),
    .data2              (data2),
    .push3              (push3),
    .data3              (data3),
    .fifo_full          (fifo_full),
    .fifo_1left_to_full (fifo_1left_to_full),
    .fifo_2left_to_full (fifo_2left_to_full),
    .fifo_3left_to_full (fifo_3left_to_full),
    .uop_valid          (uop_valid),
    .uop                (uq_uop),
    .uop_ready          (uop_ready)
  );

  // flatten the head uop onto the output pins
  assign uop_is_scalar = uq_uop.is_scalar;
  assign uop_funct     = uq_uop.funct;
  assign uop_vd        = uq_uop.vd;
  assign uop_vs2       = uq_uop.vs2;
  assign uop_vs1       = uq_uop.vs1;
  assign uop_imm       = uq_uop.imm;
  assign uop_index     = uq_uop.uop_index;
  assign uop_last      = uq_uop.last_uop;

endmodule

`default_nettype wire

// ==== source/rvv_decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_unit (
  input  wire logic                                       inst_valid,
  input  rvv_decode_pkg::inst_word_u                      inst,
  input  wire logic [rvv_decode_pkg::UOP_INDEX_WIDTH-1:0] start_index,
  decode_uop_if.unit                                      de
);
  import rvv_decode_pkg::*;

  logic [3:0]            count;
  logic [3:0]            slot_idx [NUM_DE_UOP];
  logic [NUM_DE_UOP-1:0] valid_vec;
  uop_t [NUM_DE_UOP-1:0] uop_vec;

  // group size straight from the instruction
  assign count = uop_count(inst.vv.lmul);

  always_comb begin
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      // one bit wider so start 7 plus slot 3 cannot wrap
      slot_idx[k]  = {1'b0, start_index} + 4'(k);
      valid_vec[k] = inst_valid && (slot_idx[k] < count);

      uop_vec[k].is_scalar = inst.vv.is_scalar;
      uop_vec[k].funct     = inst.vv.funct;
      uop_vec[k].vd        = inst.vv.vd + 5'(slot_idx[k]);
      uop_vec[k].vs2       = inst.vv.vs2 + 5'(slot_idx[k]);
      uop_vec[k].uop_index = slot_idx[k][UOP_INDEX_WIDTH-1:0];
      uop_vec[k].last_uop  = (slot_idx[k] == count - 4'd1);

      // scalar form keeps the immediate, vector form steps vs1
      if (inst.vv.is_scalar) begin
        uop_vec[k].vs1 = '0;
        uop_vec[k].imm = inst.vx.imm;
      end else begin
        uop_vec[k].vs1 = inst.vv.vs1 + 5'(slot_idx[k]);
        uop_vec[k].imm = '0;
      end
    end
  end

  assign de.pkg_valid = inst_valid;
  assign de.uop_valid = valid_vec;
  assign de.uop       = uop_vec;

endmodule

`default_nettype wire

// ==== source/rvv_uop_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_uop_queue #(
  parameter int UQ_DEPTH = 16
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            push0,
  input  rvv_decode_pkg::uop_t data0,
  input  wire logic            push1,
  input  rvv_decode_pkg::uop_t data1,
  input  wire logic            push2,
  input  rvv_decode_pkg::uop_t data2,
  input  wire logic            push3,
  input  rvv_decode_pkg::uop_t data3,
  output logic                 fifo_full,
  output logic                 fifo_1left_to_full,
  output logic                 fifo_2left_to_full,
  output logic                 fifo_3left_to_full,
  output logic                 uop_valid,
  output rvv_decode_pkg::uop_t uop,
  input  wire logic            uop_ready
);
  import rvv_decode_pkg::*;

  localparam int PTR_W = $clog2(UQ_DEPTH);
  localparam int SUM_W = PTR_W + 1;
  localparam int CNT_W = $clog2(UQ_DEPTH + 1);

  uop_t                  mem [UQ_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic [NUM_DE_UOP-1:0] push_vec;
  uop_t [NUM_DE_UOP-1:0] data_vec;
  logic [2:0]            push_num;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                input logic [2:0]       n);
    logic [SUM_W-1:0] sum;
    sum = {1'b0, ptr} + SUM_W'(n);
    if (sum >= SUM_W'(UQ_DEPTH)) begin
      sum = sum - SUM_W'(UQ_DEPTH);
    end
    return sum[PTR_W-1:0];
  endfunction

  assign push_vec = {push3, push2, push1, push0};
  assign data_vec = {data3, data2, data1, data0};
  // pushes are contiguous from slot 0
  assign push_num = 3'(push0) + 3'(push1) + 3'(push2) + 3'(push3);

  assign uop_valid = (count != '0);
  assign uop       = mem[rd_ptr];
  assign pop       = uop_valid & uop_ready;

  // exact levels, count moves by at most four so none is skipped
  assign fifo_full          = (count == CNT_W'(UQ_DEPTH));
  assign fifo_1left_to_full = (count == CNT_W'(UQ_DEPTH - 1));
  assign fifo_2left_to_full = (count == CNT_W'(UQ_DEPTH - 2));
  assign fifo_3left_to_full = (count == CNT_W'(UQ_DEPTH - 3));

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      if (push_vec[k]) begin
        mem[ptr_add(wr_ptr, 3'(k))] <= data_vec[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= ptr_add(wr_ptr, push_num);
      if (pop) begin
        rd_ptr <= ptr_add(rd_ptr, 3'd1);
      end
      count <= count + CNT_W'(push_num) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire
